//--- filelist.f
hw/uart_rx_pkg.sv
hw/baud_tick_gen.sv
hw/uart_rx.sv
hw/wb_rx_bank.sv
hw/uart_rx_array.sv
verification/tb_uart_rx_array.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_uart_rx_array
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_uart_rx_array.sv
`timescale 1ns/1ps

module tb_uart_rx_array
   import uart_rx_pkg::*;
   ();

   ////////////////////////////////////////////////////////////
   // Timing limits
   ////////////////////////////////////////////////////////////

   // Frame is start + 8 data + stop
   localparam int DEF_DIV    = int'(DEFAULT_DIV);
   localparam int FAST_DIV   = 1;
   localparam int FRAME_DEF  = (DATA_BITS + 2) * OVERSAMPLE * (DEF_DIV + 1);
   localparam int FRAME_FAST = (DATA_BITS + 2) * OVERSAMPLE * (FAST_DIV + 1);
   // Five frame times at default rate, one fast, plus half again
   localparam int RUN_LIMIT  = (5 * FRAME_DEF + FRAME_FAST) * 3 / 2;
   localparam int ACK_LIMIT  = 8;

   logic              i_clk;
   logic              reset;
   logic [NUM_CH-1:0] rx_line;
   wb_req_t           wb_req;
   wb_rsp_t           wb_rsp;
   integer            seed;

   uart_rx_array UUT (
      .i_clk  (i_clk),
      .reset  (reset),
      .rx     (rx_line),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   // 100 ns clock
   initial
   begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // Run length guard
   initial
   begin
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < RUN_LIMIT)
      begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d clock cycles, tests did not finish", RUN_LIMIT);
      $display("Errors found");
      $fatal(1, "Simulation stopped");
   end

   ////////////////////////////////////////////////////////////
   // Error reporting and compares
   ////////////////////////////////////////////////////////////

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_word(input string name, input logic [WB_DW-1:0] exp,
                             input logic [WB_DW-1:0] act);
      if (act !== exp)
         stop_with_error($sformatf("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
   endtask

   task automatic check_frame(input string name, input rx_frame_t exp, input rx_frame_t act);
      if (act !== exp)
         stop_with_error($sformatf("FAILED %s expected 0x%03h actual 0x%03h", name, exp, act));
   endtask

   ////////////////////////////////////////////////////////////
   // Bus and serial drivers
   ////////////////////////////////////////////////////////////

   // Request held until ack, dropped right after it
   task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                            input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
      int waited;
      waited     = 0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      do
      begin
         @(posedge i_clk);
         #1;
         waited++;
      end
      while (!wb_rsp.ack && waited < ACK_LIMIT);
      if (!wb_rsp.ack)
         stop_with_error("Wishbone slave did not acknowledge within 8 cycles");
      rdat   = wb_rsp.dat;
      wb_req = '0;
   endtask

   task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [WB_DW-1:0] dat);
      bus_cycle(1'b0, adr, 32'h0, dat);
   endtask

   task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [WB_DW-1:0] dat);
      logic [WB_DW-1:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   // One 8N1 frame on one line, LSB first
   task automatic send_byte(input int ch, input logic [DATA_BITS-1:0] value,
                            input logic stop_lvl, input int div);
      int                   bit_clks;
      logic [DATA_BITS+1:0] frame_bits;
      bit_clks   = OVERSAMPLE * (div + 1);
      frame_bits = {stop_lvl, value, 1'b0};
      for (int i = 0; i < DATA_BITS + 2; i++)
      begin
         rx_line[ch] = frame_bits[i];
         repeat (bit_clks) @(posedge i_clk);
         #1;
      end
      // Back to idle
      rx_line[ch] = 1'b1;
   endtask

   // Poll status until all channels in mask hold a byte
   task automatic wait_valid(input logic [NUM_CH-1:0] mask);
      logic [WB_DW-1:0] status;
      int               polls;
      polls = 0;
      do
      begin
         wb_read(REG_STATUS, status);
         polls++;
      end
      while ((status[NUM_CH-1:0] & mask) != mask && polls < 16);
      if ((status[NUM_CH-1:0] & mask) != mask)
         stop_with_error("Receive valid flag never came up after the frame was sent");
   endtask

   // Channel word is valid 10, overrun 9, frame_err 8, data 7:0
   task automatic read_channel(input string name, input int ch,
                               input logic [DATA_BITS-1:0] exp_data, input logic exp_ferr,
                               input logic exp_ovr, input logic exp_valid);
      logic [WB_DW-1:0] word;
      rx_frame_t        got;
      rx_frame_t        want;
      wb_read(ADR_W'(ch), word);
      want.done      = 1'b0;
      want.data      = exp_data;
      want.frame_err = exp_ferr;
      got.done       = 1'b0;
      got.data       = word[7:0];
      got.frame_err  = word[8];
      check_frame(name, want, got);
      check_word(name, {21'b0, exp_valid, exp_ovr, exp_ferr, exp_data}, word);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic reset_values();
      logic [WB_DW-1:0] word;
      wb_read(REG_DIV, word);
      check_word("reset_divisor", WB_DW'(DEFAULT_DIV), word);
      wb_read(REG_STATUS, word);
      check_word("reset_status", 32'h0, word);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         wb_read(ADR_W'(ch), word);
         check_word("reset_channel", 32'h0, word);
      end
   endtask

   // All four lines at once
   task automatic parallel_rx();
      logic [DATA_BITS-1:0] bytes [NUM_CH];
      logic [WB_DW-1:0]     word;
      for (int k = 0; k < NUM_CH; k++)
         bytes[k] = DATA_BITS'($random(seed));
      fork
         send_byte(0, bytes[0], 1'b1, DEF_DIV);
         send_byte(1, bytes[1], 1'b1, DEF_DIV);
         send_byte(2, bytes[2], 1'b1, DEF_DIV);
         send_byte(3, bytes[3], 1'b1, DEF_DIV);
      join
      wait_valid(4'hF);
      wb_read(REG_STATUS, word);
      check_word("parallel_status", 32'h0000_000F, word);
      for (int k = 0; k < NUM_CH; k++)
         read_channel("parallel_read", k, bytes[k], 1'b0, 1'b0, 1'b1);
      // Data stays, flags gone
      for (int k = 0; k < NUM_CH; k++)
         read_channel("parallel_reread", k, bytes[k], 1'b0, 1'b0, 1'b0);
   endtask

   task automatic overrun_case();
      logic [DATA_BITS-1:0] first;
      logic [DATA_BITS-1:0] second;
      logic [WB_DW-1:0]     word;
      first  = DATA_BITS'($random(seed));
      second = DATA_BITS'($random(seed));
      send_byte(1, first, 1'b1, DEF_DIV);
      send_byte(1, second, 1'b1, DEF_DIV);
      wait_valid(4'b0010);
      // Overrun in 7:4, valid in 3:0
      wb_read(REG_STATUS, word);
      check_word("overrun_status", 32'h0000_0022, word);
      read_channel("overrun_read", 1, second, 1'b0, 1'b1, 1'b1);
      read_channel("overrun_cleared", 1, second, 1'b0, 1'b0, 1'b0);
   endtask

   // Stop bit held low for the whole bit
   task automatic framing_error();
      logic [DATA_BITS-1:0] value;
      value = DATA_BITS'($random(seed));
      send_byte(2, value, 1'b0, DEF_DIV);
      wait_valid(4'b0100);
      read_channel("framing_read", 2, value, 1'b1, 1'b0, 1'b1);
   endtask

   task automatic divisor_change();
      logic [DATA_BITS-1:0] value;
      logic [WB_DW-1:0]     word;
      wb_write(REG_DIV, WB_DW'(FAST_DIV));
      wb_read(REG_DIV, word);
      check_word("divisor_fast", WB_DW'(FAST_DIV), word);
      // 32-clock bit period
      value = DATA_BITS'($random(seed));
      send_byte(3, value, 1'b1, FAST_DIV);
      wait_valid(4'b1000);
      read_channel("fast_rx", 3, value, 1'b0, 1'b0, 1'b1);
      wb_write(REG_DIV, WB_DW'(DEFAULT_DIV));
      wb_read(REG_DIV, word);
      check_word("divisor_restore", WB_DW'(DEFAULT_DIV), word);
      value = DATA_BITS'($random(seed));
      send_byte(0, value, 1'b1, DEF_DIV);
      wait_valid(4'b0001);
      read_channel("restored_rx", 0, value, 1'b0, 1'b0, 1'b1);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      seed    = 53358;
      reset   = 1'b1;
      rx_line = '1;
      wb_req  = '0;
      repeat (16) @(posedge i_clk);
      #1;
      reset = 1'b0;
      reset_values();
      parallel_rx();
      overrun_case();
      framing_error();
      divisor_change();
      $display("No errors");
      $finish;
   end

endmodule

//--- hw/uart_rx_array.sv
`timescale 1ns/1ps

module uart_rx_array
   import uart_rx_pkg::*;
   (
      input  logic              i_clk,
      input  logic              reset,
      input  logic [NUM_CH-1:0] rx,
      input  wb_req_t           wb_req,
      output wb_rsp_t           wb_rsp
   );

   logic [DIV_W-1:0] divisor;
   logic             s_tick;
   rx_frame_t        frames [NUM_CH];

   ////////////////////////////////////////////////////////////
   // Shared 16x tick
   ////////////////////////////////////////////////////////////

   baud_tick_gen u_tick (
      .i_clk   (i_clk),
      .reset   (reset),
      .divisor (divisor),
      .s_tick  (s_tick)
   );

   ////////////////////////////////////////////////////////////
   // Receivers, one per line
   ////////////////////////////////////////////////////////////

   for (genvar k = 0; k < NUM_CH; k++)
   begin : g_ch
      uart_rx u_rx (
         .i_clk  (i_clk),
         .reset  (reset),
         .rx     (rx[k]),
         .s_tick (s_tick),
         .frame  (frames[k])
      );
   end

   // Register bank, also owns the divisor
   wb_rx_bank u_bank (
      .i_clk   (i_clk),
      .reset   (reset),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .frames  (frames),
      .divisor (divisor)
   );

endmodule

//--- hw/wb_rx_bank.sv
`timescale 1ns/1ps

module wb_rx_bank
   import uart_rx_pkg::*;
   (
      input  logic             i_clk,
      input  logic             reset,
      input  wb_req_t          wb_req,
      output wb_rsp_t          wb_rsp,
      input  rx_frame_t        frames [NUM_CH],
      output logic [DIV_W-1:0] divisor
   );

   ////////////////////////////////////////////////////////////
   // Bus handshake
   ////////////////////////////////////////////////////////////

   logic             ack_reg;
   logic [WB_DW-1:0] rd_reg;
   logic             req_valid;
   wb_reg_e          reg_sel;
   logic [CH_W-1:0]  ch_sel;
   logic [NUM_CH-1:0] rd_clr;

   // New request only while ack is low
   assign req_valid = wb_req.cyc & wb_req.stb & ~ack_reg;
   assign reg_sel   = wb_reg_e'(wb_req.adr);
   assign ch_sel    = wb_req.adr[CH_W-1:0];

   // Per-channel read strobe, channel k lives at address k
   always_comb
   begin
      for (int k = 0; k < NUM_CH; k++)
         rd_clr[k] = req_valid & ~wb_req.we & (wb_req.adr == ADR_W'(k));
   end

   ////////////////////////////////////////////////////////////
   // Channel registers
   ////////////////////////////////////////////////////////////

   logic [DATA_BITS-1:0] data_reg [NUM_CH];
   logic [NUM_CH-1:0]    valid_reg;
   logic [NUM_CH-1:0]    overrun_reg;
   logic [NUM_CH-1:0]    ferr_reg;
   logic [DIV_W-1:0]     div_reg;

   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         valid_reg   <= '0;
         overrun_reg <= '0;
         ferr_reg    <= '0;
         for (int k = 0; k < NUM_CH; k++)
            data_reg[k] <= '0;
      end
      else
      begin
         for (int k = 0; k < NUM_CH; k++)
         begin
            if (frames[k].done)
            begin
               // New frame wins; overrun only if old byte was never read
               data_reg[k]    <= frames[k].data;
               ferr_reg[k]    <= frames[k].frame_err;
               valid_reg[k]   <= 1'b1;
               overrun_reg[k] <= ~rd_clr[k] & (overrun_reg[k] | valid_reg[k]);
            end
            else if (rd_clr[k])
            begin
               valid_reg[k]   <= 1'b0;
               overrun_reg[k] <= 1'b0;
               ferr_reg[k]    <= 1'b0;
            end
         end
      end
   end

   // Divisor register
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
         div_reg <= DEFAULT_DIV;
      else if (req_valid && wb_req.we && reg_sel == REG_DIV)
         div_reg <= wb_req.dat[DIV_W-1:0];
   end

   assign divisor = div_reg;

   ////////////////////////////////////////////////////////////
   // Read mux and response
   ////////////////////////////////////////////////////////////

   logic [WB_DW-1:0] rd_next;

   always_comb
   begin
      chan_word_t ch_word;
      ch_word.rsvd      = '0;
      ch_word.valid     = valid_reg[ch_sel];
      ch_word.overrun   = overrun_reg[ch_sel];
      ch_word.frame_err = ferr_reg[ch_sel];
      ch_word.data      = data_reg[ch_sel];
      case (reg_sel)
         REG_CH0, REG_CH1, REG_CH2, REG_CH3:
            rd_next = ch_word;
         REG_STATUS:
            rd_next = WB_DW'({overrun_reg, valid_reg});
         REG_DIV:
            rd_next = WB_DW'(div_reg);
         default:
            rd_next = '0;
      endcase
   end

   // Ack for one cycle, data registered alongside it
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         ack_reg <= 1'b0;
         rd_reg  <= '0;
      end
      else
      begin
         ack_reg <= req_valid;
         if (req_valid)
            rd_reg <= rd_next;
      end
   end

   assign wb_rsp.ack = ack_reg;
   assign wb_rsp.dat = rd_reg;

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
   import uart_rx_pkg::*;
   (
      input  logic      i_clk,
      input  logic      reset,
      input  logic      rx,
      input  logic      s_tick,
      output rx_frame_t frame
   );

   ////////////////////////////////////////////////////////////
   // Input synchronizer and edge detect
   ////////////////////////////////////////////////////////////

   logic [1:0] sync_reg;
   logic       rx_s;
   logic       rx_prev;
   logic       rx_fall;

   // Line idles high, so flops come out of reset high
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         sync_reg <= 2'b11;
         rx_prev  <= 1'b1;
      end
      else
      begin
         sync_reg <= {sync_reg[0], rx};
         rx_prev  <= sync_reg[1];
      end
   end

   assign rx_s    = sync_reg[1];
   assign rx_fall = rx_prev & ~rx_s;

   ////////////////////////////////////////////////////////////
   // Receive FSM
   ////////////////////////////////////////////////////////////

   rx_state_e            state_reg, state_next;
   logic [TICK_W-1:0]    s_reg, s_next;
   logic [BIT_W-1:0]     n_reg, n_next;
   logic [DATA_BITS-1:0] b_reg, b_next;
   logic                 done_tick;

   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= RX_IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
         b_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         b_reg     <= b_next;
      end
   end

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      done_tick  = 1'b0;
      case (state_reg)
         RX_IDLE:
            // Falling edge alone starts a frame
            if (rx_fall)
            begin
               state_next = RX_START;
               s_next     = '0;
            end
         RX_START:
            if (s_tick)
            begin
               // Midpoint of the start bit
               if (s_reg == TICK_W'(MID_TICK))
               begin
                  state_next = RX_DATA;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         RX_DATA:
            if (s_tick)
            begin
               if (s_reg == TICK_W'(OVERSAMPLE - 1))
               begin
                  // Shift in at bit midpoint, LSB first
                  s_next = '0;
                  b_next = {rx_s, b_reg[DATA_BITS-1:1]};
                  if (n_reg == BIT_W'(DATA_BITS - 1))
                     state_next = RX_STOP;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         RX_STOP:
            if (s_tick)
            begin
               // Last stop tick lands on the stop-bit midpoint
               if (s_reg == TICK_W'(OVERSAMPLE - 1))
               begin
                  state_next = RX_IDLE;
                  s_next     = '0;
                  done_tick  = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         default:
            state_next = RX_IDLE;
      endcase
   end

   // frame_err only meaningful while done is high
   assign frame.done      = done_tick;
   assign frame.data      = b_reg;
   assign frame.frame_err = ~rx_s;

endmodule

//--- hw/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen
   import uart_rx_pkg::*;
   (
      input  logic             i_clk,
      input  logic             reset,
      input  logic [DIV_W-1:0] divisor,
      output logic             s_tick
   );

   // Down-counter, one tick every divisor+1 clocks
   logic [DIV_W-1:0] cnt_reg;

   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         cnt_reg <= DEFAULT_DIV;
         s_tick  <= 1'b0;
      end
      else if (cnt_reg == '0)
      begin
         // New divisor only picked up here
         cnt_reg <= divisor;
         s_tick  <= 1'b1;
      end
      else
      begin
         cnt_reg <= cnt_reg - 1'b1;
         s_tick  <= 1'b0;
      end
   end

endmodule

//--- hw/uart_rx_pkg.sv
package uart_rx_pkg;

   ////////////////////////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////////////////////////

   // Receive channels and channel index width
   localparam int NUM_CH     = 4;
   localparam int CH_W       = $clog2(NUM_CH);

   // 8N1 frame, LSB first
   localparam int DATA_BITS  = 8;
   localparam int BIT_W      = $clog2(DATA_BITS);

   // Oversampling ticks per bit, start-bit midpoint tick
   localparam int OVERSAMPLE = 16;
   localparam int TICK_W     = $clog2(OVERSAMPLE);
   localparam int MID_TICK   = OVERSAMPLE / 2 - 1;

   // Tick divisor, 3 gives 4 clocks per tick
   localparam int DIV_W      = 16;
   localparam logic [DIV_W-1:0] DEFAULT_DIV = 16'd3;

   // Wishbone word address and data widths
   localparam int ADR_W      = 4;
   localparam int WB_DW      = 32;

   ////////////////////////////////////////////////////////////
   // Enums and structs
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   typedef enum logic [ADR_W-1:0] {
      REG_CH0    = 'd0,
      REG_CH1    = 'd1,
      REG_CH2    = 'd2,
      REG_CH3    = 'd3,
      REG_STATUS = 'd4,
      REG_DIV    = 'd5
   } wb_reg_e;

   // One finished frame, done is a single-cycle pulse
   typedef struct packed {
      logic                 done;
      logic [DATA_BITS-1:0] data;
      logic                 frame_err;
   } rx_frame_t;

   // Layout of a channel register read
   typedef struct packed {
      logic [WB_DW-DATA_BITS-4:0] rsvd;
      logic                       valid;
      logic                       overrun;
      logic                       frame_err;
      logic [DATA_BITS-1:0]       data;
   } chan_word_t;

   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [ADR_W-1:0] adr;
      logic [WB_DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_rsp_t;

endpackage
